/* vlog.f */
common/cart_load_pkg.sv
design/load_sequencer.sv
ram_clear/fill_generator.sv
ram_clear/fill_fifo.sv
ram_clear/fill_writer.sv
design/cart_loader.sv
bench/cart_loader_tb.sv

/* Bender.yml */
package:
  name: cart_loader

sources:
  # shared package first
  - common/cart_load_pkg.sv
  # sequencer and fill chain
  - design/load_sequencer.sv
  - ram_clear/fill_generator.sv
  - ram_clear/fill_fifo.sv
  - ram_clear/fill_writer.sv
  # top level
  - design/cart_loader.sv
  # testbench
  - target: test
    files:
      - bench/cart_loader_tb.sv

/* bench/cart_loader_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb;

  localparam int WRAM_BITS = 10;
  localparam int ARAM_BITS = 9;
  localparam int WRAM_BYTES = 1 << WRAM_BITS;
  localparam int ARAM_BYTES = 1 << ARAM_BITS;
  localparam int TOTAL_WRITES = WRAM_BYTES + ARAM_BYTES;
  localparam int FILL_TIMEOUT = 40000;
  localparam int ACK_TABLE = 2048;

  logic                       clk_sys;
  logic                       reset;
  logic                       core_reset;
  logic                       cart_download;
  cart_load_pkg::size_code_t  rom_size;
  cart_load_pkg::size_code_t  ram_size;
  cart_load_pkg::fill_mode_t  wram_fill_mode;
  cart_load_pkg::fill_mode_t  aram_fill_mode;
  logic                       wb_ack;
  cart_load_pkg::wb_req_t     wb_req;
  cart_load_pkg::addr_mask_t  rom_mask;
  cart_load_pkg::addr_mask_t  ram_mask;
  cart_load_pkg::size_code_t  sram_size;
  logic                       core_run;

  // model state shared by the slave and the main sequence
  logic [7:0]             wram_model [WRAM_BYTES];
  logic [7:0]             aram_model [ARAM_BYTES];
  cart_load_pkg::wb_req_t exp_q [$];
  int                     ack_wait [ACK_TABLE];
  int                     writes_seen;
  int                     ack_delay;
  logic                   in_cycle;

  cart_loader #(
    .WRAM_ADDR_BITS (WRAM_BITS),
    .ARAM_ADDR_BITS (ARAM_BITS),
    .FIFO_DEPTH     (4)
  ) i_dut (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .core_reset     (core_reset),
    .cart_download  (cart_download),
    .rom_size       (rom_size),
    .ram_size       (ram_size),
    .wram_fill_mode (wram_fill_mode),
    .aram_fill_mode (aram_fill_mode),
    .wb_ack         (wb_ack),
    .wb_req         (wb_req),
    .rom_mask       (rom_mask),
    .ram_mask       (ram_mask),
    .sram_size      (sram_size),
    .core_run       (core_run)
  );

  // 8 ns clock
  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  task automatic report_mismatch(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  task automatic check_write(input cart_load_pkg::wb_req_t got,
                             input cart_load_pkg::wb_req_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "write got space=%0d adr=%h dat=%h sel=%b, expected space=%0d adr=%h dat=%h sel=%b",
        got.space, got.adr, got.dat, got.sel, exp.space, exp.adr, exp.dat, exp.sel));
    end
  endtask

  task automatic check_mask(input string what, input cart_load_pkg::addr_mask_t got,
                            input cart_load_pkg::addr_mask_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_size(input string what, input cart_load_pkg::size_code_t got,
                            input cart_load_pkg::size_code_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_byte(input string what, input int addr, input logic [7:0] got,
                            input logic [7:0] exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s byte %0d got %h, expected %h", what, addr, got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      report_mismatch($sformatf("%s got %0d, expected %0d", what, got, exp));
    end
  endtask

  // pattern byte straight from the mode table
  function automatic logic [7:0] pattern_byte(input cart_load_pkg::fill_mode_t mode,
                                              input logic [16:0] addr);
    case (mode)
      cart_load_pkg::FILL_STRIPE_66_99: return (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
      cart_load_pkg::FILL_STRIPE_FF_00: return (addr[9] ^ addr[0]) ? 8'hff : 8'h00;
      cart_load_pkg::FILL_CONST_55:     return 8'h55;
      default:                          return 8'hff;
    endcase
  endfunction

  // size-code mask has ones in its low 10 + code bits
  function automatic cart_load_pkg::addr_mask_t size_mask(
      input cart_load_pkg::size_code_t code);
    cart_load_pkg::addr_mask_t m;
    int                        b;
    m = '0;
    for (b = 0; b < 10 + int'(code); b++) begin
      m[b] = 1'b1;
    end
    return m;
  endfunction

  // byte write as seen on the bus with an odd byte in the high lane
  function automatic cart_load_pkg::wb_req_t expected_write(
      input cart_load_pkg::mem_space_t space, input logic [16:0] addr, input logic [7:0] b);
    cart_load_pkg::wb_req_t w;
    w.cyc   = 1'b1;
    w.stb   = 1'b1;
    w.space = space;
    w.adr   = addr[16:1];
    w.sel   = addr[0] ? 2'b10 : 2'b01;
    w.dat   = addr[0] ? {b, 8'h00} : {8'h00, b};
    return w;
  endfunction

  // scramble the model memories and list every write of one load in order
  task automatic prepare_model(input cart_load_pkg::fill_mode_t wm,
                               input cart_load_pkg::fill_mode_t am);
    int a;
    exp_q.delete();
    writes_seen = 0;
    for (a = 0; a < WRAM_BYTES; a++) begin
      wram_model[a] = 8'(a) ^ 8'(a >> 8) ^ 8'hc3;
      exp_q.push_back(expected_write(cart_load_pkg::SPACE_WRAM, 17'(a),
                                     pattern_byte(wm, 17'(a))));
      if (a < ARAM_BYTES) begin
        aram_model[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3c;
        exp_q.push_back(expected_write(cart_load_pkg::SPACE_ARAM, 17'(a),
                                       pattern_byte(am, 17'(a))));
      end
    end
  endtask

  // one observed bus write against the model
  task automatic take_write(input cart_load_pkg::wb_req_t w);
    cart_load_pkg::wb_req_t exp;
    logic [16:0]            byte_addr;
    logic [7:0]             lane;
    if (exp_q.size() == 0) begin
      abort_run("Wishbone write seen while the model expects none");
    end
    exp = exp_q.pop_front();
    check_write(w, exp);
    byte_addr = {w.adr, w.sel[1]};
    lane      = w.sel[1] ? w.dat[15:8] : w.dat[7:0];
    if (w.space == cart_load_pkg::SPACE_WRAM) begin
      wram_model[byte_addr[WRAM_BITS-1:0]] = lane;
    end else begin
      aram_model[byte_addr[ARAM_BITS-1:0]] = lane;
    end
    writes_seen++;
  endtask

  // wishbone slave that acks after 0 to 3 wait cycles
  initial begin
    wb_ack    = 1'b0;
    in_cycle  = 1'b0;
    ack_delay = 0;
    forever begin
      @(posedge clk_sys);
      if (!reset) begin
        wb_ack   <= 1'b0;
        in_cycle = 1'b0;
      end else if (wb_ack) begin
        // DUT takes the ack on this edge
        wb_ack <= 1'b0;
      end else if (wb_req.stb) begin
        if (!in_cycle) begin
          take_write(wb_req);
          ack_delay = ack_wait[writes_seen % ACK_TABLE];
          in_cycle  = 1'b1;
        end
        if (ack_delay == 0) begin
          wb_ack   <= 1'b1;
          in_cycle = 1'b0;
        end else begin
          ack_delay--;
        end
      end
    end
  end

  task automatic wait_core_run(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (core_run !== level) begin
      if (cycles == limit) begin
        abort_run({"Timeout waiting for ", what});
      end
      @(posedge clk_sys);
      cycles++;
    end
  endtask

  // one full load with random sizes, modes and download length
  task automatic run_load(input int run);
    cart_load_pkg::size_code_t rs;
    cart_load_pkg::size_code_t qs;
    cart_load_pkg::fill_mode_t wm;
    cart_load_pkg::fill_mode_t am;
    int                        dl_len;
    int                        i;
    rs     = cart_load_pkg::size_code_t'($urandom % 13);
    // first run has no save RAM
    qs     = (run == 0) ? 4'd0 : cart_load_pkg::size_code_t'($urandom % 9);
    wm     = cart_load_pkg::fill_mode_t'($urandom % 4);
    am     = cart_load_pkg::fill_mode_t'($urandom % 4);
    dl_len = 2 + ($urandom % 30);
    prepare_model(wm, am);
    @(posedge clk_sys);
    rom_size       <= rs;
    ram_size       <= qs;
    wram_fill_mode <= wm;
    aram_fill_mode <= am;
    cart_download  <= 1'b1;
    for (i = 0; i < dl_len; i++) begin
      @(posedge clk_sys);
      // registered output lags the download by a cycle
      if (i >= 1) begin
        check_bit("core_run during download", core_run, 1'b0);
      end
    end
    cart_download <= 1'b0;
    wait_core_run(1'b1, FILL_TIMEOUT, "core_run to rise after the load");
    check_count("writes left in the model", exp_q.size(), 0);
    check_count("write count", writes_seen, TOTAL_WRITES);
    check_mask("rom_mask", rom_mask, size_mask(rs));
    check_mask("ram_mask", ram_mask, (qs == 4'd0) ? 24'd0 : size_mask(qs));
    check_size("sram_size", sram_size, qs);
    for (i = 0; i < WRAM_BYTES; i++) begin
      check_byte("work RAM", i, wram_model[i], pattern_byte(wm, 17'(i)));
    end
    for (i = 0; i < ARAM_BYTES; i++) begin
      check_byte("audio RAM", i, aram_model[i], pattern_byte(am, 17'(i)));
    end
  endtask

  // core reset request after a finished load
  task automatic pulse_core_reset();
    int len;
    len = 1 + ($urandom % 4);
    core_reset <= 1'b1;
    wait_core_run(1'b0, 4, "core_run to fall on core reset");
    repeat (len) begin
      @(posedge clk_sys);
      check_bit("core_run during core reset", core_run, 1'b0);
    end
    core_reset <= 1'b0;
    wait_core_run(1'b1, 4, "core_run to return after core reset");
  endtask

  initial begin
    int i;
    void'($urandom(32'hbbcc_a96b));
    for (i = 0; i < ACK_TABLE; i++) begin
      ack_wait[i] = $urandom % 4;
    end
    writes_seen    = 0;
    reset          = 1'b0;
    core_reset     = 1'b0;
    cart_download  = 1'b0;
    rom_size       = '0;
    ram_size       = '0;
    wram_fill_mode = cart_load_pkg::FILL_CONST_55;
    aram_fill_mode = cart_load_pkg::FILL_CONST_55;
    repeat (2) @(posedge clk_sys);
    reset <= 1'b1;
    // core held and bus quiet before any load
    repeat (20) begin
      @(posedge clk_sys);
      check_bit("core_run before first load", core_run, 1'b0);
      check_bit("bus cycle before first load", wb_req.cyc, 1'b0);
    end
    for (i = 0; i < 3; i++) begin
      run_load(i);
      pulse_core_reset();
    end
    repeat (4) @(posedge clk_sys);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* design/cart_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_loader #(
  parameter int WRAM_ADDR_BITS = 17,
  parameter int ARAM_ADDR_BITS = 16,
  parameter int FIFO_DEPTH     = 4
) (
  input  wire logic                      clk_sys,
  input  wire logic                      reset,
  input  wire logic                      core_reset,
  input  wire logic                      cart_download,
  input  wire cart_load_pkg::size_code_t  rom_size,
  input  wire cart_load_pkg::size_code_t  ram_size,
  input  wire cart_load_pkg::fill_mode_t  wram_fill_mode,
  input  wire cart_load_pkg::fill_mode_t  aram_fill_mode,
  input  wire logic                      wb_ack,
  output cart_load_pkg::wb_req_t         wb_req,
  output cart_load_pkg::addr_mask_t      rom_mask,
  output cart_load_pkg::addr_mask_t      ram_mask,
  output cart_load_pkg::size_code_t      sram_size,
  output logic                           core_run
);

  logic                      fill_start;
  logic                      fill_active;
  logic                      push;
  logic                      pop;
  logic                      full;
  logic                      empty;
  logic                      writer_busy;
  cart_load_pkg::fill_item_t gen_item;
  cart_load_pkg::fill_item_t head_item;

  // download edges, settle delay, masks and core hold
  load_sequencer i_sequencer (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .core_reset    (core_reset),
    .cart_download (cart_download),
    .rom_size      (rom_size),
    .ram_size      (ram_size),
    .fill_active   (fill_active),
    .fifo_empty    (empty),
    .writer_busy   (writer_busy),
    .fill_start    (fill_start),
    .rom_mask      (rom_mask),
    .ram_mask      (ram_mask),
    .sram_size     (sram_size),
    .core_run      (core_run)
  );

  // fill chain: walker -> FIFO -> wishbone writer
  fill_generator #(
    .WRAM_ADDR_BITS (WRAM_ADDR_BITS),
    .ARAM_ADDR_BITS (ARAM_ADDR_BITS)
  ) i_generator (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .fill_start     (fill_start),
    .wram_fill_mode (wram_fill_mode),
    .aram_fill_mode (aram_fill_mode),
    .full           (full),
    .item           (gen_item),
    .push           (push),
    .fill_active    (fill_active)
  );

  fill_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .item_in  (gen_item),
    .push     (push),
    .pop      (pop),
    .item_out (head_item),
    .full     (full),
    .empty    (empty)
  );

  fill_writer i_writer (
    .clk_sys (clk_sys),
    .reset   (reset),
    .item    (head_item),
    .empty   (empty),
    .wb_ack  (wb_ack),
    .pop     (pop),
    .busy    (writer_busy),
    .wb_req  (wb_req)
  );

endmodule

`default_nettype wire

/* ram_clear/fill_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module fill_writer (
  input  wire logic                     clk_sys,
  input  wire logic                     reset,
  input  wire cart_load_pkg::fill_item_t item,
  input  wire logic                     empty,
  input  wire logic                     wb_ack,
  output logic                          pop,
  output logic                          busy,
  output cart_load_pkg::wb_req_t        wb_req
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRAM,
    ST_ARAM
  } state_t;

  state_t                    state;
  logic                      cyc_q;
  cart_load_pkg::mem_space_t space_q;
  logic [15:0]               adr_q;
  logic [15:0]               dat_q;
  logic [1:0]                sel_q;
  logic                      issue;
  logic                      issue_aram;
  logic                      done;
  logic [7:0]                lane_byte;

  // audio write waits one idle bus cycle after the work-RAM ack
  assign issue_aram = (state == ST_ARAM) && !cyc_q;
  assign issue      = ((state == ST_IDLE) && !empty) || issue_aram;
  assign lane_byte  = issue_aram ? item.aram_data : item.wram_data;

  // current cycle acked
  assign done = cyc_q && wb_ack;

  // item leaves once its last write is acked
  assign pop  = done && ((state == ST_ARAM) || ((state == ST_WRAM) && !item.in_aram));
  assign busy = (state != ST_IDLE);

  assign wb_req = '{cyc: cyc_q, stb: cyc_q, space: space_q,
                    adr: adr_q, dat: dat_q, sel: sel_q};

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      state <= ST_IDLE;
      cyc_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (issue) begin
          cyc_q <= 1'b1;
          state <= ST_WRAM;
        end
        ST_WRAM: if (done) begin
          cyc_q <= 1'b0;
          state <= item.in_aram ? ST_ARAM : ST_IDLE;
        end
        ST_ARAM: if (issue_aram) begin
          cyc_q <= 1'b1;
        end else if (done) begin
          cyc_q <= 1'b0;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // byte-lane steering, odd byte goes high
  always_ff @(posedge clk_sys) begin
    if (issue) begin
      space_q <= issue_aram ? cart_load_pkg::SPACE_ARAM : cart_load_pkg::SPACE_WRAM;
      adr_q   <= item.addr[cart_load_pkg::WRAM_ADDR_MAX_BITS-1:1];
      sel_q   <= item.addr[0] ? 2'b10 : 2'b01;
      dat_q   <= item.addr[0] ? {lane_byte, 8'h00} : {8'h00, lane_byte};
    end
  end

  // classic handshake, master holds everything until the slave acks
  a_req_stable : assert property (
    @(posedge clk_sys) disable iff (!reset)
    (wb_req.stb && !wb_ack) |=> $stable(wb_req)
  );

endmodule

`default_nettype wire

/* ram_clear/fill_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fill_fifo #(
  parameter int DEPTH = 4
) (
  input  wire logic                     clk_sys,
  input  wire logic                     reset,
  input  wire cart_load_pkg::fill_item_t item_in,
  input  wire logic                     push,
  input  wire logic                     pop,
  output cart_load_pkg::fill_item_t     item_out,
  output logic                          full,
  output logic                          empty
);

  // pointer needs at least one bit even for a single entry
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  cart_load_pkg::fill_item_t mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  // head of the queue, valid while not empty
  assign item_out = mem[rd_ptr];
  assign full     = (count == CNT_BITS'(DEPTH));
  assign empty    = (count == '0);

  // storage only, no reset
  always_ff @(posedge clk_sys) begin
    if (push) begin
      mem[wr_ptr] <= item_in;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // wrap by compare, depth need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // generator must honour full
  a_no_push_full : assert property (
    @(posedge clk_sys) disable iff (!reset) push |-> !full
  );

  // writer only retires a present head
  a_no_pop_empty : assert property (
    @(posedge clk_sys) disable iff (!reset) pop |-> !empty
  );

endmodule

`default_nettype wire

/* ram_clear/fill_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module fill_generator #(
  parameter int WRAM_ADDR_BITS = 17,
  parameter int ARAM_ADDR_BITS = 16
) (
  input  wire logic                     clk_sys,
  input  wire logic                     reset,
  input  wire logic                     fill_start,
  input  wire cart_load_pkg::fill_mode_t wram_fill_mode,
  input  wire cart_load_pkg::fill_mode_t aram_fill_mode,
  input  wire logic                     full,
  output cart_load_pkg::fill_item_t     item,
  output logic                          push,
  output logic                          fill_active
);

  localparam int MAX_BITS = cart_load_pkg::WRAM_ADDR_MAX_BITS;

  logic [WRAM_ADDR_BITS-1:0] addr_q;
  logic [MAX_BITS-1:0]       addr_ext;
  logic                      last_addr;

  // walker address widened to the item's field
  always_comb begin
    addr_ext                     = '0;
    addr_ext[WRAM_ADDR_BITS-1:0] = addr_q;
  end

  assign last_addr = &addr_q;

  // item built straight from the walker, modes sampled as we go
  always_comb begin
    item.addr      = addr_ext;
    item.wram_data = cart_load_pkg::fill_byte(wram_fill_mode, addr_ext);
    item.aram_data = cart_load_pkg::fill_byte(aram_fill_mode, addr_ext);
    // audio RAM is smaller, only its low part gets the second write
    item.in_aram   = (addr_ext >> ARAM_ADDR_BITS) == '0;
  end

  // stall on a full FIFO
  assign push = fill_active && !full;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      fill_active <= 1'b0;
      addr_q      <= '0;
    end else if (fill_start) begin
      // restart from the bottom even mid-walk
      fill_active <= 1'b1;
      addr_q      <= '0;
    end else if (push) begin
      if (last_addr) begin
        fill_active <= 1'b0;
      end
      addr_q <= addr_q + 1'b1;
    end
  end

  // pushed addresses climb by one, or begin again at zero after a start
  a_addr_sequence : assert property (
    @(posedge clk_sys) disable iff (!reset)
    push |=> ($past(fill_start) ? (addr_q == '0)
                                : (!fill_active || addr_q == $past(addr_q) + 1'b1))
  );

endmodule

`default_nettype wire

/* design/load_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module load_sequencer (
  input  wire logic                    clk_sys,
  input  wire logic                    reset,
  input  wire logic                    core_reset,
  input  wire logic                    cart_download,
  input  wire cart_load_pkg::size_code_t rom_size,
  input  wire cart_load_pkg::size_code_t ram_size,
  input  wire logic                    fill_active,
  input  wire logic                    fifo_empty,
  input  wire logic                    writer_busy,
  output logic                         fill_start,
  output cart_load_pkg::addr_mask_t    rom_mask,
  output cart_load_pkg::addr_mask_t    ram_mask,
  output cart_load_pkg::size_code_t    sram_size,
  output logic                         core_run
);

  // counter value before any download and never decremented
  localparam logic [2:0] SETTLE_PARKED = 3'd7;

  logic       dl_q;
  logic [2:0] settle_cnt;
  logic       hold;

  // rising edge of the download starts the RAM fill
  assign fill_start = cart_download && !dl_q;

  // anything that keeps the core in reset
  // parked counter is nonzero so the core waits for the first load
  assign hold = core_reset
             || cart_download
             || (settle_cnt != 3'd0)
             || fill_active
             || !fifo_empty
             || writer_busy;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      dl_q       <= 1'b0;
      settle_cnt <= SETTLE_PARKED;
      core_run   <= 1'b0;
    end else begin
      dl_q <= cart_download;
      // falling edge reloads the parser settle delay
      if (dl_q && !cart_download) begin
        settle_cnt <= cart_load_pkg::PARSER_DELAY_LOAD;
      end else if (settle_cnt != SETTLE_PARKED && settle_cnt != 3'd0) begin
        settle_cnt <= settle_cnt - 3'd1;
      end
      core_run <= !hold;
    end
  end

  // masks taken on the last settle step once the header parse is done
  always_ff @(posedge clk_sys) begin
    if (settle_cnt == 3'd1) begin
      rom_mask  <= (24'd1024 << rom_size) - 24'd1;
      // no save RAM on the cart
      ram_mask  <= (ram_size != 4'd0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
      sram_size <= ram_size;
    end
  end

  // edge detect gives single-cycle starts only
  a_fill_start_pulse : assert property (
    @(posedge clk_sys) disable iff (!reset)
    fill_start |=> !fill_start
  );

endmodule

`default_nettype wire

/* common/cart_load_pkg.sv */
`default_nettype none

package cart_load_pkg;

  // widest work-RAM byte address a fill item can carry
  localparam int WRAM_ADDR_MAX_BITS = 17;

  // settle count loaded when the download ends
  localparam logic [2:0] PARSER_DELAY_LOAD = 3'd6;

  // rom / save-ram address mask
  typedef logic [23:0] addr_mask_t;

  // cartridge size code, mask is (1024 << code) - 1
  typedef logic [3:0] size_code_t;

  // fill pattern select, one per RAM
  typedef enum logic [1:0] {
    FILL_STRIPE_66_99 = 2'd0,
    FILL_STRIPE_FF_00 = 2'd1,
    FILL_CONST_55     = 2'd2,
    FILL_CONST_FF     = 2'd3
  } fill_mode_t;

  // one unit of fill work: a byte address and what goes into each RAM there
  typedef struct packed {
    logic [WRAM_ADDR_MAX_BITS-1:0] addr;
    logic [7:0]                    wram_data;
    logic [7:0]                    aram_data;
    // address also exists in audio RAM
    logic                          in_aram;
  } fill_item_t;

  // target of a bus write
  typedef enum logic {
    SPACE_WRAM = 1'b0,
    SPACE_ARAM = 1'b1
  } mem_space_t;

  // master side of the write-only wishbone bus
  typedef struct packed {
    logic       cyc;
    logic       stb;
    mem_space_t space;
    // 16-bit word address, byte address without bit 0
    logic [15:0] adr;
    logic [15:0] dat;
    logic [1:0]  sel;
  } wb_req_t;

  // pattern byte for one address
  function automatic logic [7:0] fill_byte(fill_mode_t mode,
                                           logic [WRAM_ADDR_MAX_BITS-1:0] addr);
    case (mode)
      // diagonal stripes, same as the console's power-on garbage
      FILL_STRIPE_66_99: fill_byte = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
      FILL_STRIPE_FF_00: fill_byte = (addr[9] ^ addr[0]) ? 8'hff : 8'h00;
      FILL_CONST_55:     fill_byte = 8'h55;
      default:           fill_byte = 8'hff;
    endcase
  endfunction

endpackage

`default_nettype wire
